// ==== run_sim.sh ====
#!/bin/sh
# Build and run the camera tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_cam_noc_tile
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_cam_noc_tile)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
   exit 0
fi
exit 1

// ==== source/cam_burst_counter.sv ====
//##########################################################
// Packet burst counter
// Counts down the payload words left in a packet
//##########################################################
`timescale 1ns/10ps

module cam_burst_counter (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic              load_i,
   input  cam_noc_pkg::len_t len_i,
   input  logic              dec_i,
   output logic              last_o
);
   import cam_noc_pkg::*;

   len_t rem_q;   // Words not yet moved onto the link

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rem_q <= '0;
      end else if (load_i) begin
         rem_q <= len_i;                  // New packet
      end else if (dec_i && rem_q != '0) begin
         rem_q <= rem_q - 1'b1;
      end
   end

   // Word taken next is the final one
   assign last_o = (rem_q == len_t'(1));

endmodule

// ==== source/cam_noc_pkg.sv ====
//##########################################################
// Camera NoC tile shared definitions
// Word, flit and tile ID types, flit type codes and
// the register map of the Wishbone slave
//##########################################################

package cam_noc_pkg;

   // Pixel word, first camera byte sits in bits 7:0
   typedef logic [31:0] word_t;

   // NoC flit: {type[1:0], data[31:0]}
   typedef logic [33:0] flit_t;
   typedef logic [1:0]  flit_type_t;

   typedef logic [4:0]  tile_id_t;   // Mesh tile address
   typedef logic [7:0]  len_t;       // Payload length in words
   typedef logic [3:0]  wb_adr_t;    // Register byte address

   // Flit type codes in bits 33:32
   localparam flit_type_t FLIT_HEAD = 2'b10;
   localparam flit_type_t FLIT_BODY = 2'b00;  // Payload, more to come
   localparam flit_type_t FLIT_TAIL = 2'b01;  // Last payload flit

   // Header class for camera traffic
   localparam logic [2:0] PKT_CLASS_CAM = 3'd2;

   // Register offsets
   localparam wb_adr_t REG_CTRL   = 4'h0;  // Enable, power-down, destination
   localparam wb_adr_t REG_FRAMES = 4'h4;  // Frame counter
   localparam wb_adr_t REG_DROPS  = 4'h8;  // Dropped words

   // Header field positions
   localparam int HDR_DEST_LSB  = 27;
   localparam int HDR_CLASS_LSB = 24;
   localparam int HDR_SRC_LSB   = 19;

   // Zero gap between source field and length byte
   localparam int HDR_PAD_W = HDR_SRC_LSB - 8;

endpackage

// ==== source/cam_noc_tile.sv ====
//##########################################################
// Camera NoC tile top level
// Capture, FIFO, packetiser and register slave
//##########################################################
`timescale 1ns/10ps

module cam_noc_tile #(
   parameter int TILE_ID     = 3,    // Own mesh address
   parameter int FIFO_DEPTH  = 16,   // Words, power of two
   parameter int BURST_WORDS = 8     // Max payload flits
) (
   input  logic                 clk,
   input  logic                 arst_n_i,
   // Camera bus
   input  logic                 pclk_i,
   input  logic                 href_i,
   input  logic                 vsync_i,
   input  logic [7:0]           cam_d_i,
   output logic                 cam_pwdn_o,
   // Register port
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_we_i,
   input  cam_noc_pkg::wb_adr_t wb_adr_i,
   input  logic [31:0]          wb_dat_i,
   input  logic [3:0]           wb_sel_i,
   output logic [31:0]          wb_dat_o,
   output logic                 wb_ack_o,
   // NoC output link
   output cam_noc_pkg::flit_t   noc_out_flit_o,
   output logic                 noc_out_valid_o,
   input  logic                 noc_out_ready_i
);
   import cam_noc_pkg::*;

   logic                        enable, frame_end, drop;
   tile_id_t                    dest;
   logic                        wr_en, rd_en;
   word_t                       wr_word, rd_word;
   logic [$clog2(FIFO_DEPTH):0] count;
   logic                        load, dec, last;
   len_t                        len;

   cam_pixel_capture u_capture (
      .clk(clk), .arst_n_i(arst_n_i), .enable_i(enable),
      .pclk_i(pclk_i), .href_i(href_i), .vsync_i(vsync_i), .cam_d_i(cam_d_i),
      .wr_en_o(wr_en), .wr_word_o(wr_word), .frame_end_o(frame_end)
   );

   cam_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .arst_n_i(arst_n_i),
      .wr_en_i(wr_en), .wr_word_i(wr_word),
      .rd_en_i(rd_en), .rd_word_o(rd_word),
      .count_o(count), .drop_o(drop)
   );

   cam_burst_counter u_counter (
      .clk(clk), .arst_n_i(arst_n_i),
      .load_i(load), .len_i(len), .dec_i(dec), .last_o(last)
   );

   cam_packet_fsm #(
      .TILE_ID(TILE_ID), .BURST_WORDS(BURST_WORDS), .FIFO_DEPTH(FIFO_DEPTH)
   ) u_fsm (
      .clk(clk), .arst_n_i(arst_n_i), .enable_i(enable), .dest_i(dest),
      .frame_end_i(frame_end), .count_i(count), .rd_word_i(rd_word),
      .rd_en_o(rd_en), .load_o(load), .len_o(len), .dec_o(dec), .last_i(last),
      .noc_out_flit_o(noc_out_flit_o), .noc_out_valid_o(noc_out_valid_o),
      .noc_out_ready_i(noc_out_ready_i)
   );

   cam_wb_regs u_regs (
      .clk(clk), .arst_n_i(arst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .frame_end_i(frame_end), .drop_i(drop),
      .enable_o(enable), .dest_o(dest), .cam_pwdn_o(cam_pwdn_o)
   );

endmodule

// ==== source/cam_packet_fsm.sv ====
//##########################################################
// Packet FSM
// Builds header, body and tail flits from FIFO words
// and drives the valid/ready NoC output link
//##########################################################
`timescale 1ns/10ps

module cam_packet_fsm #(
   parameter int TILE_ID     = 3,
   parameter int BURST_WORDS = 8,
   parameter int FIFO_DEPTH  = 16
) (
   input  logic                        clk,
   input  logic                        arst_n_i,
   input  logic                        enable_i,
   input  cam_noc_pkg::tile_id_t       dest_i,
   input  logic                        frame_end_i,
   input  logic [$clog2(FIFO_DEPTH):0] count_i,
   input  cam_noc_pkg::word_t          rd_word_i,
   output logic                        rd_en_o,
   output logic                        load_o,
   output cam_noc_pkg::len_t           len_o,
   output logic                        dec_o,
   input  logic                        last_i,
   output cam_noc_pkg::flit_t          noc_out_flit_o,
   output logic                        noc_out_valid_o,
   input  logic                        noc_out_ready_i
);
   import cam_noc_pkg::*;

   localparam int            CW        = $clog2(FIFO_DEPTH) + 1;
   localparam logic [CW-1:0] BURST_CNT = CW'(BURST_WORDS);

   typedef enum logic [1:0] {IDLE, HEAD, PAYLOAD} state_e;

   state_e     state_q;
   flit_t      flit_q;
   flit_t      head_flit;
   flit_type_t cur_type;
   logic       valid_q, pend_q;   // pend_q: frame end waiting for drain
   logic       fifo_empty, start, accept;

   assign fifo_empty = (count_i == '0);
   assign cur_type   = flit_q[33:32];
   assign accept     = valid_q & noc_out_ready_i;   // Link handshake

   // Full burst ready, or leftover words after a frame end
   assign start = (state_q == IDLE) & enable_i &
                  ((count_i >= BURST_CNT) | (pend_q & ~fifo_empty));

   assign len_o  = (count_i >= BURST_CNT) ? len_t'(BURST_WORDS) : len_t'(count_i);
   assign load_o = start;

   // Next word enters the flit register when the current flit leaves
   assign rd_en_o = accept & ((state_q == HEAD) |
                              ((state_q == PAYLOAD) & (cur_type != FLIT_TAIL)));
   assign dec_o   = rd_en_o;   // One count per payload word put on the link

   assign head_flit = {FLIT_HEAD, dest_i, PKT_CLASS_CAM, tile_id_t'(TILE_ID),
                       {HDR_PAD_W{1'b0}}, len_o};

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
         valid_q <= 1'b0;
         pend_q  <= 1'b0;
      end else begin
         if (frame_end_i)
            pend_q <= 1'b1;
         else if (fifo_empty)
            pend_q <= 1'b0;     // Frame remainder gone
         case (state_q)
            IDLE: begin
               if (start) begin
                  state_q <= HEAD;
                  valid_q <= 1'b1;   // Header valid next cycle
               end
            end
            HEAD: begin
               if (accept) state_q <= PAYLOAD;
            end
            PAYLOAD: begin
               if (accept && cur_type == FLIT_TAIL) begin
                  state_q <= IDLE;
                  valid_q <= 1'b0;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Held while stalled since only start or a pop reloads it
   always_ff @(posedge clk) begin
      if (start)
         flit_q <= head_flit;
      else if (rd_en_o)
         flit_q <= {last_i ? FLIT_TAIL : FLIT_BODY, rd_word_i};
   end

   assign noc_out_flit_o  = flit_q;
   assign noc_out_valid_o = valid_q;

endmodule

// ==== source/cam_pixel_capture.sv ====
//##########################################################
// Camera pixel capture
// Brings the parallel camera bus into clk, packs bytes
// into 32 bit words and flags line and frame ends
//##########################################################
`timescale 1ns/10ps

module cam_pixel_capture (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               enable_i,
   input  logic               pclk_i,
   input  logic               href_i,
   input  logic               vsync_i,
   input  logic [7:0]         cam_d_i,
   output logic               wr_en_o,
   output cam_noc_pkg::word_t wr_word_o,
   output logic               frame_end_o
);
   import cam_noc_pkg::*;

   logic [10:0] cam_meta_q, cam_sync_q;  // {vsync, href, pclk, d}
   logic        pclk_d_q, href_d_q, vsync_d_q;
   logic        pclk_s, href_s, vsync_s;
   logic [7:0]  d_s;
   logic        pclk_rise, href_fall, vsync_rise;
   logic        push_full, push_part;
   word_t       lane_q, word_q;
   logic [1:0]  byte_cnt_q;               // Next byte lane
   logic        wr_en_q, frame_end_q;

   assign d_s     = cam_sync_q[7:0];
   assign pclk_s  = cam_sync_q[8];
   assign href_s  = cam_sync_q[9];
   assign vsync_s = cam_sync_q[10];

   assign pclk_rise  = pclk_s & ~pclk_d_q;
   assign href_fall  = ~href_s & href_d_q;   // End of line
   assign vsync_rise = vsync_s & ~vsync_d_q;

   // Fourth byte completes a word; a line end flushes a partial one
   assign push_full = enable_i & pclk_rise & href_s & (byte_cnt_q == 2'd3);
   assign push_part = enable_i & href_fall & (byte_cnt_q != 2'd0);

   // Two stage sync, then one more stage for edge detection
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cam_meta_q <= '0;
         cam_sync_q <= '0;
         pclk_d_q   <= 1'b0;
         href_d_q   <= 1'b0;
         vsync_d_q  <= 1'b0;
      end else begin
         cam_meta_q <= {vsync_i, href_i, pclk_i, cam_d_i};
         cam_sync_q <= cam_meta_q;
         pclk_d_q   <= pclk_s;
         href_d_q   <= href_s;
         vsync_d_q  <= vsync_s;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lane_q      <= '0;
         byte_cnt_q  <= 2'd0;
         wr_en_q     <= 1'b0;
         frame_end_q <= 1'b0;
      end else begin
         wr_en_q     <= push_full | push_part;  // One cycle push strobe
         frame_end_q <= vsync_rise;
         if (!enable_i) begin
            lane_q     <= '0;   // Drop any half built word
            byte_cnt_q <= 2'd0;
         end else if (push_full || push_part) begin
            lane_q     <= '0;   // Cleared lanes give the zero padding
            byte_cnt_q <= 2'd0;
         end else if (pclk_rise && href_s) begin
            lane_q[8*byte_cnt_q +: 8] <= d_s;
            byte_cnt_q                <= byte_cnt_q + 2'd1;
         end
      end
   end

   // Output word holds still until the FIFO takes it
   always_ff @(posedge clk) begin
      if (push_full)
         word_q <= {d_s, lane_q[23:0]};
      else if (push_part)
         word_q <= lane_q;
   end

   assign wr_en_o     = wr_en_q;
   assign wr_word_o   = word_q;
   assign frame_end_o = frame_end_q;

endmodule

// ==== source/cam_wb_regs.sv ====
//##########################################################
// Camera tile register slave
// Wishbone classic access to control, frame count
// and dropped word count
//##########################################################
`timescale 1ns/10ps

module cam_wb_regs (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   input  cam_noc_pkg::wb_adr_t  wb_adr_i,
   input  logic [31:0]           wb_dat_i,
   input  logic [3:0]            wb_sel_i,
   output logic [31:0]           wb_dat_o,
   output logic                  wb_ack_o,
   input  logic                  frame_end_i,
   input  logic                  drop_i,
   output logic                  enable_o,
   output cam_noc_pkg::tile_id_t dest_o,
   output logic                  cam_pwdn_o
);
   import cam_noc_pkg::*;

   logic        ack_q;
   logic        enable_q, pwdn_q;
   tile_id_t    dest_q;
   logic [31:0] frames_q, drops_q;
   logic [31:0] rd_data_q;
   logic        req, wr;

   // New request, not the tail of one already acked
   assign req = wb_cyc_i & wb_stb_i & ~ack_q;
   assign wr  = req & wb_we_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q    <= 1'b0;
         enable_q <= 1'b0;
         pwdn_q   <= 1'b0;
         dest_q   <= '0;
         frames_q <= '0;
         drops_q  <= '0;
      end else begin
         ack_q <= req;   // Single cycle ack
         if (wr && wb_adr_i == REG_CTRL) begin
            if (wb_sel_i[0]) {pwdn_q, enable_q} <= wb_dat_i[1:0];
            if (wb_sel_i[1]) dest_q <= wb_dat_i[12:8];
         end
         // Counters clear on any write
         if (wr && wb_adr_i == REG_FRAMES)
            frames_q <= '0;
         else if (frame_end_i && enable_q)
            frames_q <= frames_q + 32'd1;
         if (wr && wb_adr_i == REG_DROPS)
            drops_q <= '0;
         else if (drop_i)
            drops_q <= drops_q + 32'd1;
      end
   end

   // Read data captured with the request
   always_ff @(posedge clk) begin
      if (req) begin
         case (wb_adr_i)
            REG_CTRL:   rd_data_q <= {19'd0, dest_q, 6'd0, pwdn_q, enable_q};
            REG_FRAMES: rd_data_q <= frames_q;
            REG_DROPS:  rd_data_q <= drops_q;
            default:    rd_data_q <= '0;   // Unmapped
         endcase
      end
   end

   assign wb_dat_o   = rd_data_q;
   assign wb_ack_o   = ack_q;
   assign enable_o   = enable_q;
   assign dest_o     = dest_q;
   assign cam_pwdn_o = pwdn_q;

endmodule

// ==== source/cam_word_fifo.sv ====
//##########################################################
// Camera word FIFO
// First word fall-through buffer with fill count,
// writes into a full FIFO are dropped and reported
//##########################################################
`timescale 1ns/10ps

module cam_word_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          wr_en_i,
   input  cam_noc_pkg::word_t            wr_word_i,
   input  logic                          rd_en_i,
   output cam_noc_pkg::word_t            rd_word_o,
   output logic [$clog2(FIFO_DEPTH):0]   count_o,
   output logic                          drop_o
);
   import cam_noc_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);

   word_t         mem_q [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr_q, rd_ptr_q;   // Wrap naturally, depth is 2^AW
   logic [AW:0]   count_q;
   logic          full, empty, wr_ok, rd_ok;

   assign full  = (count_q == (AW+1)'(FIFO_DEPTH));
   assign empty = (count_q == '0);
   assign wr_ok = wr_en_i & ~full;
   assign rd_ok = rd_en_i & ~empty;     // Ignore pops on empty

   always_ff @(posedge clk) begin
      if (wr_ok)
         mem_q[wr_ptr_q] <= wr_word_i;
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
         if (wr_ok && !rd_ok)
            count_q <= count_q + 1'b1;
         else if (rd_ok && !wr_ok)
            count_q <= count_q - 1'b1;
      end
   end

   assign rd_word_o = mem_q[rd_ptr_q];   // Head word, no read latency
   assign count_o   = count_q;
   assign drop_o    = wr_en_i & full;    // Word lost

endmodule

// ==== tb/cam_noc_tile_chk.sv ====
//##########################################################
// Camera NoC tile protocol checker
// Link and Wishbone properties, bound to the top level
//##########################################################
`timescale 1ns/10ps

module cam_noc_tile_chk (
   input logic                clk,
   input logic                arst_n_i,
   input cam_noc_pkg::flit_t  flit_i,
   input logic                valid_i,
   input logic                ready_i,
   input logic                ack_i
);
   import cam_noc_pkg::*;

   logic        in_pkt_q;   // Header seen, tail still due
   logic        xfer;
   int unsigned fail_cnt = 0;   // Failed properties so far

   assign xfer = valid_i & ready_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i)
         in_pkt_q <= 1'b0;
      else if (xfer && flit_i[33:32] == FLIT_HEAD)
         in_pkt_q <= 1'b1;
      else if (xfer && flit_i[33:32] == FLIT_TAIL)
         in_pkt_q <= 1'b0;
   end

   // Stalled flit holds
   a_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_i && !ready_i |=> valid_i && $stable(flit_i))
      else begin
         $error("flit changed under back-pressure");
         fail_cnt++;
      end

   a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
      ack_i |=> !ack_i)
      else begin
         $error("ack longer than one cycle");
         fail_cnt++;
      end

   a_reset: assert property (@(posedge clk) !arst_n_i |-> !valid_i && !ack_i)
      else begin
         $error("valid or ack high in reset");
         fail_cnt++;
      end

   // No header inside a packet, no payload outside one
   a_head: assert property (@(posedge clk) disable iff (!arst_n_i)
      xfer && flit_i[33:32] == FLIT_HEAD |-> !in_pkt_q)
      else begin
         $error("header before tail");
         fail_cnt++;
      end

   a_body: assert property (@(posedge clk) disable iff (!arst_n_i)
      xfer && flit_i[33:32] != FLIT_HEAD |-> in_pkt_q)
      else begin
         $error("payload without header");
         fail_cnt++;
      end

endmodule

bind cam_noc_tile cam_noc_tile_chk u_chk (
   .clk(clk), .arst_n_i(arst_n_i),
   .flit_i(noc_out_flit_o), .valid_i(noc_out_valid_o),
   .ready_i(noc_out_ready_i), .ack_i(wb_ack_o)
);

// ==== tb/tb_cam_noc_tile.sv ====
//##########################################################
// Camera NoC tile testbench
// Register, camera and link stimulus with a flit scoreboard
//##########################################################
`timescale 1ns/10ps

module tb_cam_noc_tile;
   import cam_noc_pkg::*;

   localparam int TILE_ID     = 3;
   localparam int FIFO_DEPTH  = 16;
   localparam int BURST_WORDS = 8;
   localparam logic [31:0] CTRL_MASK = 32'h0000_1F03;  // dest, pwdn, enable

   logic        clk, arst_n_i;
   logic        pclk_i, href_i, vsync_i, cam_pwdn_o;
   logic [7:0]  cam_d_i;
   logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   wb_adr_t     wb_adr_i;
   logic [31:0] wb_dat_i, wb_dat_o;
   logic [3:0]  wb_sel_i;
   flit_t       noc_out_flit_o;
   logic        noc_out_valid_o, noc_out_ready_i;

   word_t       exp_q[$];           // Words expected on the link
   tile_id_t    exp_dest;
   logic        in_pkt, hung, en_model;
   int          rem_flits, ready_mode;  // ready_mode: 0 low, 1 high, 2 random
   int          errors, tests, failed_tests, err_start, valid_cycles;
   int          exp_frames;          // Frame count of the model
   logic [31:0] rd;

   cam_noc_tile #(.TILE_ID(TILE_ID), .FIFO_DEPTH(FIFO_DEPTH), .BURST_WORDS(BURST_WORDS)) UUT (
      .clk(clk), .arst_n_i(arst_n_i),
      .pclk_i(pclk_i), .href_i(href_i), .vsync_i(vsync_i), .cam_d_i(cam_d_i),
      .cam_pwdn_o(cam_pwdn_o),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
      .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .noc_out_flit_o(noc_out_flit_o), .noc_out_valid_o(noc_out_valid_o),
      .noc_out_ready_i(noc_out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Link sink, throttled by mode
   always @(posedge clk) begin
      case (ready_mode)
         0:       noc_out_ready_i <= 1'b0;
         1:       noc_out_ready_i <= 1'b1;
         default: noc_out_ready_i <= 1'($urandom % 2);
      endcase
   end

   // Scoreboard on each accepted flit
   always @(posedge clk) begin
      if (noc_out_valid_o) valid_cycles++;
      if (noc_out_valid_o && noc_out_ready_i) check_flit(noc_out_flit_o);
   end

   task automatic check_flit(input flit_t f);
      word_t w;
      if (f[33:32] == FLIT_HEAD) begin
         assert (!in_pkt && f[31:27] == exp_dest && f[26:24] == PKT_CLASS_CAM &&
                 f[23:19] == tile_id_t'(TILE_ID) && f[18:8] == '0 &&
                 f[7:0] != 8'd0 && f[7:0] <= 8'(BURST_WORDS)) else begin
            $display("[FAIL] %0t: bad header %h", $time, f);
            errors++;
         end
         in_pkt    = 1'b1;
         rem_flits = int'(f[7:0]);  // Payload flits still due
      end else begin
         rem_flits--;
         w = (exp_q.size() != 0) ? exp_q.pop_front() : 32'hDEAD_BEEF;
         assert (in_pkt && f[31:0] == w) else begin
            $display("[FAIL] %0t: payload %h expected %h", $time, f[31:0], w);
            errors++;
         end
         assert ((f[33:32] == FLIT_TAIL) == (rem_flits == 0) && f[33:32] != 2'b11) else begin
            $display("[FAIL] %0t: flit type %b with %0d left", $time, f[33:32], rem_flits);
            errors++;
         end
         if (f[33:32] == FLIT_TAIL || rem_flits <= 0) in_pkt = 1'b0;
      end
   endtask

   task automatic wb_access(input logic we, input wb_adr_t adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= wdata;
      wb_sel_i <= 4'hF;
      @(posedge clk);
      while (!wb_ack_o && waited < 20) begin
         @(posedge clk);
         waited++;
      end
      if (!wb_ack_o) begin
         $display("Wishbone access at %h got no ack", adr);
         hung = 1'b1;
      end
      rdata = wb_dat_o;
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic wb_read_check(input wb_adr_t adr, input logic [31:0] expected);
      logic [31:0] data;
      wb_access(1'b0, adr, '0, data);
      assert (data == expected) else begin
         $display("[FAIL] %0t: reg %h read %h expected %h", $time, adr, data, expected);
         errors++;
      end
   endtask

   task automatic check_pwdn(input logic expected);
      assert (cam_pwdn_o == expected) else begin
         $display("[FAIL] %0t: cam_pwdn_o %b expected %b", $time, cam_pwdn_o, expected);
         errors++;
      end
   endtask

   // One line of random bytes; only the first keep_words reach the model
   task automatic drive_line(input int nbytes, input int keep_words);
      logic [7:0] b;
      word_t      w;
      int         lane, words, i;
      w = '0;
      lane = 0;
      words = 0;
      for (i = 0; i < nbytes; i++) begin
         b = 8'($urandom);
         w[8*lane +: 8] = b;
         @(posedge clk);
         href_i  <= 1'b1;
         cam_d_i <= b;
         pclk_i  <= 1'b0;
         repeat (4) @(posedge clk);
         pclk_i <= 1'b1;          // Byte sampled on this rise
         repeat (3) @(posedge clk);
         if (lane == 3) begin
            if (words < keep_words) exp_q.push_back(w);
            words++;
            w = '0;
            lane = 0;
         end else lane++;
      end
      if (lane != 0 && words < keep_words) exp_q.push_back(w);  // Zero padded tail
      @(posedge clk);
      pclk_i <= 1'b0;
      repeat (4) @(posedge clk);
      href_i <= 1'b0;
      repeat (8) @(posedge clk);
   endtask

   task automatic pulse_vsync();
      if (en_model) exp_frames++;   // Counted only while enabled
      @(posedge clk);
      vsync_i <= 1'b1;
      repeat (16) @(posedge clk);
      vsync_i <= 1'b0;
      repeat (8) @(posedge clk);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0 || in_pkt) && waited < 5000) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0 || in_pkt) begin
         $display("Link did not deliver %0d expected words in time", exp_q.size());
         hung = 1'b1;
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors != err_start || hung) failed_tests++;
      $display("test %-12s %s", name, (errors != err_start || hung) ? "failed" : "ok");
      err_start = errors;
   endtask

   initial begin
      void'($urandom(67156));
      arst_n_i = 1'b0;
      {pclk_i, href_i, vsync_i, cam_d_i} = '0;
      {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i, wb_sel_i} = '0;
      noc_out_ready_i = 1'b0;
      ready_mode = 1;
      {errors, tests, failed_tests, err_start, valid_cycles, rem_flits} = '0;
      in_pkt = 1'b0;
      hung = 1'b0;
      en_model = 1'b0;
      exp_frames = 0;
      exp_dest = 5'd5;
      repeat (5) @(posedge clk);
      arst_n_i <= 1'b1;
      repeat (2) @(posedge clk);

      check_pwdn(1'b0);          // Camera powered after reset
      wb_read_check(REG_FRAMES, 32'd0);
      wb_read_check(REG_DROPS, 32'd0);
      wb_access(1'b1, REG_CTRL, 32'hFFFF_FFFF, rd);
      en_model = 1'b1;
      check_pwdn(1'b1);
      wb_read_check(REG_CTRL, CTRL_MASK);
      wb_access(1'b1, REG_CTRL, 32'h0000_0501, rd);  // dest 5, enable
      check_pwdn(1'b0);
      wb_read_check(REG_CTRL, 32'h0000_0501 & CTRL_MASK);
      wb_read_check(4'hC, 32'd0);
      finish_test("registers");

      if (!hung) begin
         drive_line(64, 64);      // Two full bursts
         wait_drain();
      end
      finish_test("header");
      if (!hung) begin
         drive_line(37, 64);      // Partial last word, flushed by the frame end
         pulse_vsync();
         wait_drain();
      end
      finish_test("payload");

      if (!hung) begin
         ready_mode = 2;
         drive_line(30, 64);
         drive_line(26, 64);      // Short remainder left for the frame end
         pulse_vsync();
         wait_drain();
         wb_read_check(REG_FRAMES, 32'(exp_frames));
         ready_mode = 1;
      end
      finish_test("backpressure");

      if (!hung) begin
         ready_mode = 0;
         wb_access(1'b1, REG_DROPS, '0, rd);
         drive_line(4 * (FIFO_DEPTH + 4), FIFO_DEPTH);
         wb_read_check(REG_DROPS, 32'd4);
         ready_mode = 1;
         wait_drain();
      end
      finish_test("overflow");

      if (!hung) begin
         wb_access(1'b1, REG_CTRL, 32'h0000_0500, rd);
         en_model = 1'b0;
         valid_cycles = 0;
         drive_line(40, 0);
         pulse_vsync();
         assert (valid_cycles == 0) else begin
            $display("[FAIL] %0t: %0d valid cycles while disabled", $time, valid_cycles);
            errors++;
         end
         wb_read_check(REG_FRAMES, 32'(exp_frames));
      end
      finish_test("disable");

      $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (errors == 0 && !hung && UUT.u_chk.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
source/cam_noc_pkg.sv
source/cam_pixel_capture.sv
source/cam_word_fifo.sv
source/cam_burst_counter.sv
source/cam_packet_fsm.sv
source/cam_wb_regs.sv
source/cam_noc_tile.sv
tb/cam_noc_tile_chk.sv
tb/tb_cam_noc_tile.sv
